/* include/game_defs.svh */
/*
 * Game geometry and physics constants
 * Shared by the level core RTL and its testbench
 */
`ifndef GAME_DEFS_SVH
`define GAME_DEFS_SVH

// Level layout
`define GD_BLOCK_NUM      7
`define GD_PLAT_NUM       7

// Coordinates are unsigned, heights carry one extra sign bit
`define GD_PHY_WIDTH      16

// One screen of climbing
`define GD_BLOCK_HEIGHT   480

// Platform length code, max 15 steps
`define GD_LEN_WIDTH      4

// Horizontal units per length step
`define GD_LEN_UNIT       8

// Vertical physics, in units per frame
`define GD_JUMP_VEL       12
`define GD_GRAVITY        1

// Terminal fall speed
`define GD_MAX_FALL       (-12)

`endif

/* verilog/game_pkg.sv */
/*
 * Game types
 * Position, speed and index words used across the level core
 */
`include "game_defs.svh"

package game_pkg;

    // Character height, signed so a fall can overshoot below the floor
    typedef logic signed [`GD_PHY_WIDTH:0] pos_t;

    // X, platform offsets and block base
    typedef logic [`GD_PHY_WIDTH-1:0] coord_t;

    // Vertical speed, positive is up
    typedef logic signed [7:0] vel_t;

    typedef logic [3:0] blk_t;

    typedef logic [4:0] cam_t;

    typedef logic [`GD_LEN_WIDTH-1:0] len_t;

endpackage

/* verilog/block_gen.sv */
/*
 * Block generator
 * Maps the character height to camera index and block type,
 * flags block changes and serves the platform layout of the current block
 */
`timescale 1ns/1ps
`include "game_defs.svh"

module block_gen import game_pkg::*; (
    input  logic                          sys_clk,
    input  logic                          sys_rst_n,
    input  pos_t                          char_y,
    output cam_t                          camera_y,
    output blk_t                          cur_block_type,
    output coord_t                        block_base,
    output coord_t [0:`GD_PLAT_NUM-1]     plat_x,
    output coord_t [0:`GD_PLAT_NUM-1]     plat_y,
    output len_t   [0:`GD_PLAT_NUM-1]     plat_len,
    output logic                          block_switch,
    output logic                          switch_up
);

    coord_t y_pos;
    cam_t   cam_next;
    blk_t   blk_next;
    coord_t base_next;

    // Nothing below the floor
    assign y_pos     = (char_y < 0) ? '0 : char_y[`GD_PHY_WIDTH-1:0];
    assign cam_next  = cam_t'(y_pos / `GD_BLOCK_HEIGHT);
    assign blk_next  = blk_t'(cam_next % `GD_BLOCK_NUM);
    assign base_next = coord_t'(cam_next * `GD_BLOCK_HEIGHT);

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            camera_y       <= '0;
            cur_block_type <= '0;
            block_base     <= '0;
        end else begin
            camera_y       <= cam_next;
            cur_block_type <= blk_next;
            block_base     <= base_next;
        end
    end

    // Single pulse as the new type lands in cur_block_type
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            block_switch <= 1'b0;
        end else begin
            block_switch <= (blk_next != cur_block_type);
        end
    end

    // Direction of the last camera move, held until the next one
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            switch_up <= 1'b0;
        end else if (cam_next != camera_y) begin
            switch_up <= (cam_next > camera_y);
        end
    end

    // Layout table, y relative to block_base
    // Layout 0 also serves the unused codes
    always_comb begin
        case (cur_block_type)
            4'd1: begin
                plat_x   = '{200, 40, 320, 120, 360, 180, 20};
                plat_y   = '{30, 110, 150, 230, 300, 380, 440};
                plat_len = '{10, 12, 8, 10, 10, 13, 8};
            end
            4'd2: begin
                plat_x   = '{200, 100, 0, 200, 100, 0, 180};
                plat_y   = '{30, 75, 135, 195, 255, 315, 375};
                plat_len = '{10, 6, 6, 6, 6, 6, 13};
            end
            4'd3: begin
                plat_x   = '{330, 60, 280, 140, 200, 250, 170};
                plat_y   = '{20, 70, 160, 140, 280, 340, 380};
                plat_len = '{6, 6, 4, 6, 4, 6, 6};
            end
            4'd4: begin
                plat_x   = '{240, 70, 360, 0, 400, 440, 160};
                plat_y   = '{20, 180, 200, 340, 320, 400, 430};
                plat_len = '{10, 5, 5, 3, 3, 4, 13};
            end
            4'd5: begin
                plat_x   = '{200, 0, 350, 150, 220, 350, 150};
                plat_y   = '{30, 40, 200, 200, 300, 390, 390};
                plat_len = '{8, 5, 5, 5, 5, 5, 5};
            end
            4'd6: begin
                plat_x   = '{50, 300, 130, 400, 220, 60, 350};
                plat_y   = '{20, 50, 130, 220, 280, 350, 380};
                plat_len = '{10, 10, 4, 10, 10, 10, 10};
            end
            default: begin
                // Staggered column around x 200..223, one jump apart
                plat_x   = '{200, 160, 200, 160, 200, 176, 400};
                plat_y   = '{75, 150, 225, 300, 375, 450, 120};
                plat_len = '{10, 8, 10, 8, 10, 8, 6};
            end
        endcase
    end

endmodule

/* verilog/char_motion.sv */
/*
 * Character vertical motion
 * Position and speed registers stepped once per frame tick
 */
`timescale 1ns/1ps
`include "game_defs.svh"

module char_motion import game_pkg::*; (
    input  logic sys_clk,
    input  logic sys_rst_n,
    input  logic frame_tick,
    input  logic jump,
    input  logic land,
    input  pos_t land_y,
    output pos_t char_y,
    output vel_t vel_y,
    output pos_t next_y,
    output logic on_ground
);

    vel_t vel_dec;
    vel_t vel_fall;

    // Where this frame's speed would take us
    assign next_y = char_y + pos_t'(vel_y);

    // Gravity with terminal speed
    assign vel_dec  = vel_y - vel_t'(`GD_GRAVITY);
    assign vel_fall = (vel_dec < vel_t'(`GD_MAX_FALL)) ? vel_t'(`GD_MAX_FALL) : vel_dec;

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            char_y    <= '0;
            vel_y     <= '0;
            on_ground <= 1'b1;
        end else if (frame_tick) begin
            if (jump && on_ground) begin
                // Takeoff frame, speed is still zero so y stays put
                char_y    <= next_y;
                vel_y     <= vel_t'(`GD_JUMP_VEL);
                on_ground <= 1'b0;
            end else if (land) begin
                char_y    <= land_y;
                vel_y     <= '0;
                on_ground <= 1'b1;
            end else begin
                // Airborne, also walking off an edge
                char_y    <= next_y;
                vel_y     <= vel_fall;
                on_ground <= 1'b0;
            end
        end
    end

endmodule

/* verilog/plat_collide.sv */
/*
 * Platform collision
 * Checks the floor and all platforms of the current block against
 * this frame's fall and returns the highest top that catches it
 */
`timescale 1ns/1ps
`include "game_defs.svh"

module plat_collide import game_pkg::*; (
    input  coord_t                        char_x,
    input  pos_t                          char_y,
    input  pos_t                          next_y,
    input  vel_t                          vel_y,
    input  coord_t                        block_base,
    input  coord_t [0:`GD_PLAT_NUM-1]     plat_x,
    input  coord_t [0:`GD_PLAT_NUM-1]     plat_y,
    input  len_t   [0:`GD_PLAT_NUM-1]     plat_len,
    output logic                          land,
    output pos_t                          land_y
);

    localparam int XW = `GD_PHY_WIDTH + 1;

    logic falling;
    logic floor_hit;
    pos_t top [`GD_PLAT_NUM];
    logic hit [`GD_PLAT_NUM];

    // Platforms are one-way, only a stationary or falling character lands
    assign falling   = (vel_y <= 0);
    assign floor_hit = falling && (next_y <= 0);

    for (genvar i = 0; i < `GD_PLAT_NUM; i++) begin : g_plat
        logic [XW-1:0] span_end;
        logic          in_span;

        assign top[i]   = {1'b0, coord_t'(block_base + plat_y[i])};
        // Extra bit so the right edge cannot wrap
        assign span_end = {1'b0, plat_x[i]} + XW'(plat_len[i]) * XW'(`GD_LEN_UNIT);
        assign in_span  = (char_x >= plat_x[i]) && ({1'b0, char_x} < span_end);

        // Top inside the window next_y..char_y
        assign hit[i] = falling && in_span && (top[i] <= char_y) && (top[i] >= next_y);
    end

    always_comb begin : pick_top
        logic found;
        pos_t best;

        found = floor_hit;
        best  = '0;
        for (int i = 0; i < `GD_PLAT_NUM; i++) begin
            if (hit[i] && (!found || top[i] > best)) begin
                found = 1'b1;
                best  = top[i];
            end
        end
        land   = found;
        land_y = best;
    end

endmodule

/* verilog/jump_core.sv */
/*
 * Jump game level core
 * Vertical motion, platform landing and block tracking
 */
`timescale 1ns/1ps
`include "game_defs.svh"

module jump_core import game_pkg::*; (
    input  logic   sys_clk,
    input  logic   sys_rst_n,
    input  logic   frame_tick,
    input  logic   jump,
    input  coord_t char_x,
    output pos_t   char_y,
    output logic   on_ground,
    output cam_t   camera_y,
    output blk_t   cur_block_type,
    output logic   block_switch,
    output logic   switch_up
);

    vel_t                      vel_y;
    pos_t                      next_y;
    logic                      land;
    pos_t                      land_y;
    coord_t                    block_base;
    coord_t [0:`GD_PLAT_NUM-1] plat_x;
    coord_t [0:`GD_PLAT_NUM-1] plat_y;
    len_t   [0:`GD_PLAT_NUM-1] plat_len;

    char_motion u_char_motion (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .frame_tick (frame_tick),
        .jump       (jump),
        .land       (land),
        .land_y     (land_y),
        .char_y     (char_y),
        .vel_y      (vel_y),
        .next_y     (next_y),
        .on_ground  (on_ground)
    );

    // Layout follows char_y one cycle later
    block_gen u_block_gen (
        .sys_clk        (sys_clk),
        .sys_rst_n      (sys_rst_n),
        .char_y         (char_y),
        .camera_y       (camera_y),
        .cur_block_type (cur_block_type),
        .block_base     (block_base),
        .plat_x         (plat_x),
        .plat_y         (plat_y),
        .plat_len       (plat_len),
        .block_switch   (block_switch),
        .switch_up      (switch_up)
    );

    plat_collide u_plat_collide (
        .char_x     (char_x),
        .char_y     (char_y),
        .next_y     (next_y),
        .vel_y      (vel_y),
        .block_base (block_base),
        .plat_x     (plat_x),
        .plat_y     (plat_y),
        .plat_len   (plat_len),
        .land       (land),
        .land_y     (land_y)
    );

endmodule

/* tests/jump_core_chk.sv */
/*
 * Assertions for the level core
 * Switch pulse width, frame-locked motion and ground state
 */
`timescale 1ns/1ps

module jump_core_chk import game_pkg::*; (
    input logic sys_clk,
    input logic sys_rst_n,
    input logic frame_tick,
    input pos_t char_y,
    input vel_t vel_y,
    input logic on_ground,
    input logic block_switch
);

    int fail_count = 0;

    a_switch_pulse: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        block_switch |=> !block_switch
    ) else begin
        $error("block_switch high for more than one cycle");
        fail_count++;
    end

    // Height only moves on the edge that sampled a tick
    a_frame_locked: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        (char_y != $past(char_y)) |-> $past(frame_tick)
    ) else begin
        $error("char_y changed without a frame_tick");
        fail_count++;
    end

    a_ground_still: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        on_ground |-> (vel_y == '0)
    ) else begin
        $error("on_ground set while vel_y is %0d", vel_y);
        fail_count++;
    end

endmodule

bind jump_core jump_core_chk u_chk (
    .sys_clk      (sys_clk),
    .sys_rst_n    (sys_rst_n),
    .frame_tick   (frame_tick),
    .char_y       (char_y),
    .vel_y        (vel_y),
    .on_ground    (on_ground),
    .block_switch (block_switch)
);

/* tests/jump_core_tb.sv */
/*
 * Testbench for the jump game level core
 * Replays frame patterns from a file, checks height, landing and block tracking
 */
`timescale 1ns/1ps
`include "game_defs.svh"

module jump_core_tb import game_pkg::*; ();

    logic   sys_clk;
    logic   sys_rst_n;
    logic   frame_tick;
    logic   jump;
    coord_t char_x;
    pos_t   char_y;
    logic   on_ground;
    cam_t   camera_y;
    blk_t   cur_block_type;
    logic   block_switch;
    logic   switch_up;

    // One entry per pattern line
    int   pat_frames[$];
    int   pat_jump[$];
    int   pat_x[$];
    int   pat_y[$];
    int   pat_og[$];
    int   total_frames = 0;
    logic pat_loaded = 1'b0;

    jump_core u_dut (
        .sys_clk        (sys_clk),
        .sys_rst_n      (sys_rst_n),
        .frame_tick     (frame_tick),
        .jump           (jump),
        .char_x         (char_x),
        .char_y         (char_y),
        .on_ground      (on_ground),
        .camera_y       (camera_y),
        .cur_block_type (cur_block_type),
        .block_switch   (block_switch),
        .switch_up      (switch_up)
    );

    initial begin : clock_gen
        sys_clk = 1'b0;
        forever #5 sys_clk = ~sys_clk;
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_pos(input string name, input pos_t got, input pos_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_cam(input string name, input cam_t got, input cam_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_blk(input string name, input blk_t got, input blk_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s = %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Heights below the floor count as screen 0
    function automatic cam_t cam_of_height(input pos_t h);
        int y;
        y = (h < 0) ? 0 : int'(h);
        return cam_t'(y / `GD_BLOCK_HEIGHT);
    endfunction

    task automatic load_patterns();
        int    fd;
        int    n;
        int    frames;
        int    jmp;
        int    x;
        int    y;
        int    og;
        string line;

        fd = $fopen("tests/jump_patterns.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open the pattern file tests/jump_patterns.txt");
            abort_run();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Comment and blank lines yield no fields
                n = $sscanf(line, "%d %d %d %d %d", frames, jmp, x, y, og);
                if (n == 5) begin
                    pat_frames.push_back(frames);
                    pat_jump.push_back(jmp);
                    pat_x.push_back(x);
                    pat_y.push_back(y);
                    pat_og.push_back(og);
                    total_frames += frames;
                end
            end
            $fclose(fd);
        end
    endtask

    // Pulse frame_tick, then watch block_switch up to the next drive point
    task automatic step_frame(input logic jmp, input coord_t x, inout int pulses);
        jump       = jmp;
        char_x     = x;
        frame_tick = 1'b1;
        @(posedge sys_clk);
        #1;
        frame_tick = 1'b0;
        repeat (3) begin
            @(posedge sys_clk);
            #1;
            if (block_switch) begin
                pulses++;
            end
        end
    endtask

    initial begin : watchdog
        wait (pat_loaded);
        #((total_frames + 10) * 4 * 10);
        $display("ERROR: timeout, the pattern run did not complete in time");
        abort_run();
    end

    initial begin : stimulus
        int   pulses;
        pos_t exp_y;
        cam_t exp_cam;
        cam_t prev_cam;
        blk_t exp_blk;
        blk_t prev_blk;
        logic exp_up;

        sys_rst_n  = 1'b0;
        frame_tick = 1'b0;
        jump       = 1'b0;
        char_x     = '0;
        load_patterns();
        if (pat_frames.size() == 0) begin
            $display("ERROR: the pattern file holds no frames");
            abort_run();
        end
        pat_loaded = 1'b1;

        repeat (4) @(posedge sys_clk);
        #1;
        sys_rst_n = 1'b1;

        check_pos("char_y", char_y, '0);
        check_bit("on_ground", on_ground, 1'b1);
        check_cam("camera_y", camera_y, '0);
        check_blk("cur_block_type", cur_block_type, '0);
        check_bit("block_switch", block_switch, 1'b0);
        check_bit("switch_up", switch_up, 1'b0);
        prev_cam = '0;
        prev_blk = '0;
        exp_up   = 1'b0;

        for (int i = 0; i < pat_frames.size(); i++) begin
            pulses = 0;
            for (int f = 0; f < pat_frames[i]; f++) begin
                step_frame(pat_jump[i] != 0, coord_t'(pat_x[i]), pulses);
            end
            exp_y   = pos_t'(pat_y[i]);
            exp_cam = cam_of_height(exp_y);
            exp_blk = blk_t'(exp_cam % `GD_BLOCK_NUM);
            // Direction flag holds between camera moves
            if (exp_cam != prev_cam) begin
                exp_up = (exp_cam > prev_cam);
            end
            check_pos("char_y", char_y, exp_y);
            check_bit("on_ground", on_ground, pat_og[i] != 0);
            check_cam("camera_y", camera_y, exp_cam);
            check_blk("cur_block_type", cur_block_type, exp_blk);
            check_bit("block_switch pulse", pulses != 0, exp_blk != prev_blk);
            check_bit("block_switch extra pulse", pulses > 1, 1'b0);
            check_bit("switch_up", switch_up, exp_up);
            prev_cam = exp_cam;
            prev_blk = exp_blk;
        end

        if (u_dut.u_chk.fail_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("ERROR: %0d assertion failures in jump_core_chk", u_dut.u_chk.fail_count);
            abort_run();
        end
    end

endmodule

/* tests/jump_patterns.txt */
# frames jump char_x exp_char_y exp_on_ground
# Inputs are held for that many frame ticks, outputs are checked after the last one
# Idle on the floor
 2 0 100   0 1
# Jump just right of platform 0, pass its top and fall back to the floor
 1 1 280   0 0
 1 0 280  12 0
 1 0 280  23 0
 1 0 280  33 0
 9 0 280  78 0
 1 0 280  78 0
 1 0 280  77 0
 1 0 280  75 0
 9 0 280  12 0
 1 0 280   0 1
# Land on platform 0 and stay there
 1 1 210   0 0
14 0 210  77 0
 1 0 210  75 1
 2 0 210  75 1
# Climb the column, one jump per platform
16 1 210 150 1
16 1 210 225 1
16 1 210 300 1
16 1 210 375 1
16 1 210 450 1
# Over the top into block 1, miss its first platform, drop back onto 450
 1 1 210 450 0
 2 0 210 473 0
 1 0 210 483 0
 9 0 210 528 0
 7 0 280 507 0
 3 0 280 483 0
 1 0 210 473 0
 1 0 210 462 0
 1 0 210 450 1

/* filelist.f */
+incdir+include
verilog/game_pkg.sv
verilog/block_gen.sv
verilog/char_motion.sv
verilog/plat_collide.sv
verilog/jump_core.sv
tests/jump_core_chk.sv
tests/jump_core_tb.sv

/* Makefile */
VERILATOR  := verilator
TOP        := jump_core_tb
FILELIST   := filelist.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --assert -j 0
OBJ_DIR    := obj_dir
SIM_LOG    := sim.log
PASS_MSG   := PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(SIM_LOG) 2>&1; cat $(SIM_LOG)
	@grep -qx "$(PASS_MSG)" $(SIM_LOG) || { echo "Simulation failed, see $(SIM_LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)
